//--- Bender.yml
package:
  name: lpf_coef_calc

sources:
  - source/lpf_fixed_pkg.sv
  - source/lpf_seq_pkg.sv
  - source/cc_to_omega.sv
  - source/trig_series.sv
  - source/recip_divider.sv
  - source/mac_slice.sv
  - source/lpf_coef_sequencer.sv
  - source/lpf_coef_calc.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_lpf_coef_calc.sv

//--- source/cc_to_omega.sv
`timescale 1ns/1ps

module cc_to_omega import lpf_fixed_pkg::*; #(
    parameter q_t OMEGA0_MAX = 18'sd25736
) (
    input  logic       reset,
    input  logic       clk,
    input  logic       load,
    input  logic [6:0] cc_omega0,
    output q_t         omega0,
    output logic       omega_ready
);

    logic signed [63:0] frac_prod;
    q_t                 frac_scaled;

    // Fractional octave from the table, whole octaves by shifting
    always_comb begin
        frac_prod   = OMEGA0_MAX * exp2_frac(cc_omega0[3:0]);
        frac_scaled = sat_q(frac_prod >>> Q_FRAC);
    end

    always_ff @(posedge reset) begin
        if (load) begin
            omega0 <= frac_scaled >>> cc_omega0[6:4];
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            omega_ready <= 1'b0;
        end else begin
            omega_ready <= load;
        end
    end

endmodule

//--- source/lpf_coef_calc.sv
`timescale 1ns/1ps

module lpf_coef_calc import lpf_fixed_pkg::*, lpf_seq_pkg::*; #(
    parameter q_t OMEGA0_MAX = 18'sd25736
) (
    input  logic       reset,
    input  logic       clk,
    input  logic       do_calc,
    input  logic [6:0] cc_omega0,
    input  logic [6:0] cc_inv_2q,
    output logic       busy,
    output logic       coef_valid,
    output q_t         coef_b0,
    output q_t         coef_b1,
    output q_t         coef_b2,
    output q_t         coef_a1,
    output q_t         coef_a2
);

    logic    omega_load;
    logic    omega_ready;
    q_t      omega0;
    logic    trig_start;
    logic    trig_done;
    q_t      sin_w;
    q_t      cos_w;
    logic    recip_start;
    logic    recip_done;
    q_t      recip_den;
    q_t      recip_q;
    mac_op_e mac_op;
    q_t      mac_a;
    q_t      mac_b;
    q_t      mac_c;
    q_t      mac_p;

    lpf_coef_sequencer i_lpf_coef_sequencer (
        .reset       (reset),
        .clk         (clk),
        .do_calc     (do_calc),
        .cc_inv_2q   (cc_inv_2q),
        .omega_ready (omega_ready),
        .trig_done   (trig_done),
        .sin_w       (sin_w),
        .cos_w       (cos_w),
        .recip_done  (recip_done),
        .recip_q     (recip_q),
        .mac_p       (mac_p),
        .omega_load  (omega_load),
        .trig_start  (trig_start),
        .recip_start (recip_start),
        .recip_den   (recip_den),
        .mac_op      (mac_op),
        .mac_a       (mac_a),
        .mac_b       (mac_b),
        .mac_c       (mac_c),
        .busy        (busy),
        .coef_valid  (coef_valid),
        .coef_b0     (coef_b0),
        .coef_b1     (coef_b1),
        .coef_b2     (coef_b2),
        .coef_a1     (coef_a1),
        .coef_a2     (coef_a2)
    );

    cc_to_omega #(
        .OMEGA0_MAX (OMEGA0_MAX)
    ) i_cc_to_omega (
        .reset       (reset),
        .clk         (clk),
        .load        (omega_load),
        .cc_omega0   (cc_omega0),
        .omega0      (omega0),
        .omega_ready (omega_ready)
    );

    trig_series i_trig_series (
        .reset  (reset),
        .clk    (clk),
        .start  (trig_start),
        .omega0 (omega0),
        .sin_w  (sin_w),
        .cos_w  (cos_w),
        .done   (trig_done)
    );

    recip_divider i_recip_divider (
        .reset (reset),
        .clk   (clk),
        .start (recip_start),
        .den   (recip_den),
        .quot  (recip_q),
        .done  (recip_done)
    );

    mac_slice i_mac_slice (
        .reset (reset),
        .clk   (clk),
        .op    (mac_op),
        .a     (mac_a),
        .b     (mac_b),
        .c     (mac_c),
        .p     (mac_p)
    );

endmodule

//--- source/lpf_coef_sequencer.sv
`timescale 1ns/1ps

module lpf_coef_sequencer import lpf_fixed_pkg::*, lpf_seq_pkg::*; (
    input  logic       reset,
    input  logic       clk,
    input  logic       do_calc,
    input  logic [6:0] cc_inv_2q,
    input  logic       omega_ready,
    input  logic       trig_done,
    input  q_t         sin_w,
    input  q_t         cos_w,
    input  logic       recip_done,
    input  q_t         recip_q,
    input  q_t         mac_p,
    output logic       omega_load,
    output logic       trig_start,
    output logic       recip_start,
    output q_t         recip_den,
    output mac_op_e    mac_op,
    output q_t         mac_a,
    output q_t         mac_b,
    output q_t         mac_c,
    output logic       busy,
    output logic       coef_valid,
    output q_t         coef_b0,
    output q_t         coef_b1,
    output q_t         coef_b2,
    output q_t         coef_a1,
    output q_t         coef_a2
);

    localparam q_t NEG_TWO = -18'sd131072;

    seq_state_e state;
    logic [2:0] step;
    q_t         inv_2q_r;
    q_t         slot_r [0:4];
    coef_idx_e  norm_idx;
    logic       iss_wr;
    coef_idx_e  iss_idx;
    logic [1:0] wr_v;
    coef_idx_e  wr_idx [0:1];

    assign busy        = (state != S_IDLE);
    // Both controller values are taken on the strobe itself
    assign omega_load  = (state == S_IDLE) && do_calc;
    assign trig_start  = (state == S_TRIG);
    assign recip_start = (state == S_RECIP);
    // a0 is parked in the b0 slot until the divider takes it
    assign recip_den   = slot_r[CI_B0];
    assign norm_idx    = coef_idx_e'(step);

    // ------------------------------------------------------------------------
    // Multiply-add issue
    // ------------------------------------------------------------------------
    always_comb begin
        mac_op  = MAC_NOP;
        mac_a   = '0;
        mac_b   = '0;
        mac_c   = '0;
        iss_wr  = 1'b0;
        iss_idx = CI_B0;
        case (state)
            S_ALPHA: begin
                // a0 = alpha + 1, then a2 = 1 - alpha
                mac_a   = sin_w;
                mac_b   = inv_2q_r;
                mac_c   = Q_ONE;
                iss_wr  = 1'b1;
                mac_op  = (step == 3'd0) ? MAC_MUL_ADD : MAC_MUL_SUB;
                iss_idx = (step == 3'd0) ? CI_B0 : CI_A2;
            end
            S_RAW: begin
                // b1 = 1 - cos, then a1 = -2 cos
                mac_a   = cos_w;
                mac_b   = (step == 3'd0) ? Q_ONE : NEG_TWO;
                mac_c   = Q_ONE;
                iss_wr  = 1'b1;
                mac_op  = (step == 3'd0) ? MAC_MUL_SUB : MAC_MUL;
                iss_idx = (step == 3'd0) ? CI_B1 : CI_A1;
            end
            S_NORM: begin
                mac_a   = slot_r[norm_idx];
                mac_b   = recip_q;
                iss_wr  = 1'b1;
                mac_op  = MAC_MUL;
                iss_idx = norm_idx;
            end
            default: ;
        endcase
    end

    // Write-back flag and slot follow the two stages of the slice
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            wr_v      <= 2'b00;
            wr_idx[0] <= CI_B0;
            wr_idx[1] <= CI_B0;
        end else begin
            wr_v      <= {wr_v[0], iss_wr};
            wr_idx[0] <= iss_idx;
            wr_idx[1] <= wr_idx[0];
        end
    end

    always_ff @(posedge reset) begin
        if (wr_v[1]) begin
            slot_r[wr_idx[1]] <= mac_p;
        end
        if (state == S_WAIT_RECIP && recip_done) begin
            slot_r[CI_B0] <= slot_r[CI_B1] >>> 1;
            slot_r[CI_B2] <= slot_r[CI_B1] >>> 1;
        end
        if (state == S_IDLE && do_calc) begin
            inv_2q_r <= sat_q($signed({46'd0, {1'b0, cc_inv_2q} + 8'd1, 10'd0}));
        end
    end

    // ------------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state <= S_IDLE;
            step  <= 3'd0;
        end else begin
            case (state)
                S_IDLE:       if (do_calc) state <= S_OMEGA;
                S_OMEGA:      if (omega_ready) state <= S_TRIG;
                S_TRIG:       state <= S_WAIT_TRIG;
                S_WAIT_TRIG: begin
                    step <= 3'd0;
                    if (trig_done) state <= S_ALPHA;
                end
                S_ALPHA: begin
                    step <= (step == 3'd1) ? 3'd0 : step + 3'd1;
                    if (step == 3'd1) state <= S_RAW;
                end
                S_RAW: begin
                    step <= (step == 3'd1) ? 3'd0 : step + 3'd1;
                    if (step == 3'd1) state <= S_RECIP;
                end
                S_RECIP:      state <= S_WAIT_RECIP;
                S_WAIT_RECIP: if (recip_done) state <= S_NORM;
                S_NORM: begin
                    step <= (step == 3'd4) ? 3'd0 : step + 3'd1;
                    if (step == 3'd4) state <= S_DRAIN;
                end
                S_DRAIN: begin
                    step <= (step == 3'd1) ? 3'd0 : step + 3'd1;
                    if (step == 3'd1) state <= S_DONE;
                end
                default:      state <= S_IDLE;
            endcase
        end
    end

    // Output registers hold until the next finished calculation
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            coef_valid <= 1'b0;
            coef_b0    <= '0;
            coef_b1    <= '0;
            coef_b2    <= '0;
            coef_a1    <= '0;
            coef_a2    <= '0;
        end else begin
            coef_valid <= (state == S_DONE);
            if (state == S_DONE) begin
                coef_b0 <= slot_r[CI_B0];
                coef_b1 <= slot_r[CI_B1];
                coef_b2 <= slot_r[CI_B2];
                coef_a1 <= slot_r[CI_A1];
                coef_a2 <= slot_r[CI_A2];
            end
        end
    end

    a_trig_one_at_a_time: assert property (
        @(posedge reset) disable iff (clk)
        trig_start |=> (!trig_start throughout trig_done[->1]));

    a_recip_one_at_a_time: assert property (
        @(posedge reset) disable iff (clk)
        recip_start |=> (!recip_start throughout recip_done[->1]));

    a_valid_single: assert property (
        @(posedge reset) disable iff (clk) coef_valid |=> !coef_valid);

endmodule

//--- source/lpf_fixed_pkg.sv
package lpf_fixed_pkg;

    localparam int Q_W    = 18;
    localparam int Q_FRAC = 16;

    // Signed Q2.16
    typedef logic signed [Q_W-1:0] q_t;

    localparam q_t Q_ONE = 18'sd65536;

    // round(65536 * 2^(-k/16))
    function automatic q_t exp2_frac(input logic [3:0] k);
        case (k)
            4'h0:    return 18'sd65536;
            4'h1:    return 18'sd62757;
            4'h2:    return 18'sd60097;
            4'h3:    return 18'sd57549;
            4'h4:    return 18'sd55109;
            4'h5:    return 18'sd52773;
            4'h6:    return 18'sd50535;
            4'h7:    return 18'sd48393;
            4'h8:    return 18'sd46341;
            4'h9:    return 18'sd44376;
            4'ha:    return 18'sd42495;
            4'hb:    return 18'sd40693;
            4'hc:    return 18'sd38968;
            4'hd:    return 18'sd37316;
            4'he:    return 18'sd35734;
            default: return 18'sd34219;
        endcase
    endfunction

    // Clamp a wide signed value into the q_t range
    function automatic q_t sat_q(input logic signed [63:0] v);
        if (v > 64'sd131071) begin
            return 18'sd131071;
        end else if (v < -64'sd131072) begin
            return -18'sd131072;
        end
        return v[Q_W-1:0];
    endfunction

endpackage

//--- source/lpf_seq_pkg.sv
package lpf_seq_pkg;

    // Coefficient sequencer states
    typedef enum logic [3:0] {
        S_IDLE,
        S_OMEGA,
        S_TRIG,
        S_WAIT_TRIG,
        S_ALPHA,
        S_RAW,
        S_RECIP,
        S_WAIT_RECIP,
        S_NORM,
        S_DRAIN,
        S_DONE
    } seq_state_e;

    // Multiply-add opcodes, products are (a*b)>>>16
    typedef enum logic [1:0] {
        MAC_NOP,
        MAC_MUL,
        MAC_MUL_ADD,
        MAC_MUL_SUB
    } mac_op_e;

    // Coefficient slots
    typedef enum logic [2:0] {
        CI_B0,
        CI_B1,
        CI_B2,
        CI_A1,
        CI_A2
    } coef_idx_e;

endpackage

//--- source/mac_slice.sv
`timescale 1ns/1ps

module mac_slice import lpf_fixed_pkg::*, lpf_seq_pkg::*; (
    input  logic    reset,
    input  logic    clk,
    input  mac_op_e op,
    input  q_t      a,
    input  q_t      b,
    input  q_t      c,
    output q_t      p
);

    mac_op_e            op_r;
    q_t                 a_r;
    q_t                 b_r;
    q_t                 c_r;
    logic signed [63:0] prod;

    always_comb begin
        prod = a_r * b_r;
        prod = prod >>> Q_FRAC;
    end

    // Operand stage
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            op_r <= MAC_NOP;
        end else begin
            op_r <= op;
        end
    end

    always_ff @(posedge reset) begin
        a_r <= a;
        b_r <= b;
        c_r <= c;
    end

    // Result stage
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            p <= '0;
        end else begin
            case (op_r)
                MAC_MUL:     p <= sat_q(prod);
                MAC_MUL_ADD: p <= sat_q(prod + 64'(c_r));
                MAC_MUL_SUB: p <= sat_q(64'(c_r) - prod);
                default:     p <= '0;
            endcase
        end
    end

    a_op_known: assert property (
        @(posedge reset) disable iff (clk) !$isunknown(op));

endmodule

//--- source/recip_divider.sv
`timescale 1ns/1ps

module recip_divider import lpf_fixed_pkg::*; (
    input  logic reset,
    input  logic clk,
    input  logic start,
    input  q_t   den,
    output q_t   quot,
    output logic done
);

    logic        busy;
    logic [5:0]  bit_cnt;
    logic [16:0] den_r;
    logic [18:0] rem;
    logic [33:0] qbits;
    logic [18:0] rem_sh;
    logic [18:0] rem_nxt;
    logic [33:0] qbits_nxt;

    // Dividend bits shift out of qbits while quotient bits shift in
    always_comb begin
        rem_sh = {rem[17:0], qbits[33]};
        if (rem_sh >= {2'b00, den_r}) begin
            rem_nxt   = rem_sh - {2'b00, den_r};
            qbits_nxt = {qbits[32:0], 1'b1};
        end else begin
            rem_nxt   = rem_sh;
            qbits_nxt = {qbits[32:0], 1'b0};
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            busy    <= 1'b0;
            bit_cnt <= 6'd0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy    <= 1'b1;
                bit_cnt <= 6'd0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 6'd1;
                if (bit_cnt == 6'd33) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge reset) begin
        if (start && !busy) begin
            den_r <= den[16:0];
            rem   <= '0;
            qbits <= 34'h1_0000_0000;
        end else if (busy) begin
            rem   <= rem_nxt;
            qbits <= qbits_nxt;
            if (bit_cnt == 6'd33) begin
                quot <= sat_q($signed({30'd0, qbits_nxt}));
            end
        end
    end

    a_den_positive: assert property (
        @(posedge reset) disable iff (clk) (start && !busy) |-> (den > 0));

endmodule

//--- source/trig_series.sv
`timescale 1ns/1ps

module trig_series import lpf_fixed_pkg::*; (
    input  logic reset,
    input  logic clk,
    input  logic start,
    input  q_t   omega0,
    output q_t   sin_w,
    output q_t   cos_w,
    output logic done
);

    // round(65536/k)
    localparam q_t K2  = 18'sd32768;
    localparam q_t K6  = 18'sd10923;
    localparam q_t K12 = 18'sd5461;
    localparam q_t K20 = 18'sd3277;
    localparam q_t K30 = 18'sd2185;

    logic       busy;
    logic [2:0] step;
    q_t         w_r;
    q_t         x2_r;
    q_t         s_acc;
    q_t         c_acc;
    q_t         mx;
    q_t         mk;
    q_t         ma;
    q_t         prod;
    q_t         horner;

    function automatic q_t qmul(input q_t a, input q_t b);
        logic signed [63:0] wide;
        wide = a * b;
        return sat_q(wide >>> Q_FRAC);
    endfunction

    // Steps run x2, s1, c1, s2, c2, c3, then sin
    // Each Horner level is 1 - (x2*K)*acc
    always_comb begin
        mx = x2_r;
        mk = K20;
        ma = Q_ONE;
        case (step)
            3'd0: begin
                mx = w_r;
                mk = w_r;
            end
            3'd1: mk = K20;
            3'd2: mk = K30;
            3'd3: begin
                mk = K6;
                ma = s_acc;
            end
            3'd4: begin
                mk = K12;
                ma = c_acc;
            end
            3'd5: begin
                mk = K2;
                ma = c_acc;
            end
            default: begin
                mx = w_r;
                mk = s_acc;
            end
        endcase
        prod   = qmul(qmul(mx, mk), ma);
        horner = sat_q(64'(Q_ONE) - 64'(prod));
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            busy <= 1'b0;
            step <= 3'd0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
                step <= 3'd0;
            end else if (busy) begin
                step <= step + 3'd1;
                if (step == 3'd6) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge reset) begin
        if (start && !busy) begin
            w_r <= omega0;
        end else if (busy) begin
            case (step)
                3'd0:    x2_r  <= prod;
                3'd1:    s_acc <= horner;
                3'd2:    c_acc <= horner;
                3'd3:    s_acc <= horner;
                3'd4:    c_acc <= horner;
                3'd5:    c_acc <= horner;
                default: begin
                    sin_w <= prod;
                    cos_w <= c_acc;
                end
            endcase
        end
    end

    // done comes seven steps after the accepted start
    a_done_after_start: assert property (
        @(posedge reset) disable iff (clk) $rose(done) |-> $past(start && !busy, 8));

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic reset,
    output logic clk
);

    localparam time HALF_PERIOD = 5ns;
    localparam int  RESET_CYCLES = 4;

    // 10 ns clock on reset, active high reset on clk
    initial begin
        reset = 1'b0;
        forever #(HALF_PERIOD) reset = ~reset;
    end

    initial begin
        clk = 1'b1;
        repeat (RESET_CYCLES) @(posedge reset);
        #1 clk = 1'b0;
    end

endmodule

//--- tb/tb_lpf_coef_calc.sv
`timescale 1ns/1ps

module tb_lpf_coef_calc import lpf_fixed_pkg::*, lpf_seq_pkg::*; ();

    localparam q_t OMEGA0_MAX     = 18'sd25736;
    localparam int N_RANDOM       = 40;
    localparam int N_CALCS        = 5 + N_RANDOM + 1;
    localparam int TIMEOUT_CYCLES = (N_CALCS + 2) * 100;

    // Series constants round(65536/k)
    localparam q_t K_2  = 18'sd32768;
    localparam q_t K_6  = 18'sd10923;
    localparam q_t K_12 = 18'sd5461;
    localparam q_t K_20 = 18'sd3277;
    localparam q_t K_30 = 18'sd2185;

    typedef struct packed {
        q_t b0;
        q_t b1;
        q_t b2;
        q_t a1;
        q_t a2;
    } coef_set_t;

    logic       reset;
    logic       clk;
    logic       do_calc;
    logic [6:0] cc_omega0;
    logic [6:0] cc_inv_2q;
    logic       busy;
    logic       coef_valid;
    q_t         coef_b0;
    q_t         coef_b1;
    q_t         coef_b2;
    q_t         coef_a1;
    q_t         coef_a2;

    coef_set_t   pending [$];
    coef_set_t   held;
    logic        prev_valid;
    int          done_count;
    int          cycle_count;
    logic [15:0] lfsr_state;

    tb_clock_gen i_tb_clock_gen (
        .reset (reset),
        .clk   (clk)
    );

    lpf_coef_calc #(
        .OMEGA0_MAX (OMEGA0_MAX)
    ) i_lpf_coef_calc (
        .reset      (reset),
        .clk        (clk),
        .do_calc    (do_calc),
        .cc_omega0  (cc_omega0),
        .cc_inv_2q  (cc_inv_2q),
        .busy       (busy),
        .coef_valid (coef_valid),
        .coef_b0    (coef_b0),
        .coef_b1    (coef_b1),
        .coef_b2    (coef_b2),
        .coef_a1    (coef_a1),
        .coef_a2    (coef_a2)
    );

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic q_t trunc_product(input q_t a, input q_t b);
        return sat_q((longint'(a) * longint'(b)) >>> Q_FRAC);
    endfunction

    function automatic q_t one_minus(input q_t v);
        return sat_q(longint'(Q_ONE) - longint'(v));
    endfunction

    function automatic coef_set_t lpf_model(input logic [6:0] cc_w, input logic [6:0] cc_q);
        coef_set_t res;
        q_t        frac;
        q_t        w;
        q_t        x2;
        q_t        s_acc;
        q_t        c_acc;
        q_t        sin_v;
        q_t        inv_2q;
        q_t        alpha;
        q_t        a0;
        q_t        r0;
        q_t        b1;
        frac   = sat_q((longint'(OMEGA0_MAX) * longint'(exp2_frac(cc_w[3:0]))) >>> Q_FRAC);
        w      = frac >>> cc_w[6:4];
        x2     = trunc_product(w, w);
        // Horner from the innermost bracket outward
        s_acc  = one_minus(trunc_product(x2, K_20));
        s_acc  = one_minus(trunc_product(trunc_product(x2, K_6), s_acc));
        sin_v  = trunc_product(w, s_acc);
        c_acc  = one_minus(trunc_product(x2, K_30));
        c_acc  = one_minus(trunc_product(trunc_product(x2, K_12), c_acc));
        c_acc  = one_minus(trunc_product(trunc_product(x2, K_2), c_acc));
        inv_2q = sat_q((longint'(cc_q) + 1) * 1024);
        alpha  = trunc_product(sin_v, inv_2q);
        a0     = sat_q(longint'(alpha) + longint'(Q_ONE));
        r0     = sat_q(64'sh1_0000_0000 / longint'(a0));
        b1     = one_minus(c_acc);
        res.b1 = trunc_product(b1, r0);
        res.b0 = trunc_product(b1 >>> 1, r0);
        res.b2 = res.b0;
        res.a1 = trunc_product(trunc_product(c_acc, -18'sd131072), r0);
        res.a2 = trunc_product(one_minus(alpha), r0);
        return res;
    endfunction

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    function automatic string coef_port_name(input coef_idx_e idx);
        case (idx)
            CI_B0:   return "coef_b0";
            CI_B1:   return "coef_b1";
            CI_B2:   return "coef_b2";
            CI_A1:   return "coef_a1";
            default: return "coef_a2";
        endcase
    endfunction

    task automatic check_coef(input coef_idx_e idx, input q_t actual, input q_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: %s expected 0x%05h actual 0x%05h",
                                coef_port_name(idx), expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: %s expected 0x%0h actual 0x%0h",
                                name, expected, actual));
        end
    endtask

    task automatic check_all(input coef_set_t exp_set);
        check_coef(CI_B0, coef_b0, exp_set.b0);
        check_coef(CI_B1, coef_b1, exp_set.b1);
        check_coef(CI_B2, coef_b2, exp_set.b2);
        check_coef(CI_A1, coef_a1, exp_set.a1);
        check_coef(CI_A2, coef_a2, exp_set.a2);
    endtask

    // Compare on the falling edge where outputs have settled
    always @(negedge reset) begin
        if (!clk) begin
            if (coef_valid) begin
                if (prev_valid) begin
                    check_flag("coef_valid", coef_valid, 1'b0);
                end
                if (pending.size() == 0) begin
                    abort_run("coef_valid rose with no calculation pending");
                end
                held       = pending.pop_front();
                check_all(held);
                done_count = done_count + 1;
            end else begin
                // Outputs hold between results
                check_all(held);
            end
            prev_valid = coef_valid;
        end
    end

    always @(posedge reset) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: run did not finish within %0d cycles",
                                TIMEOUT_CYCLES));
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [6:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v          = {v[5:0], lfsr_state[0]};
        end
    endtask

    task automatic issue_calc(input logic [6:0] cc_w, input logic [6:0] cc_q);
        while (busy) @(negedge reset);
        @(posedge reset);
        #1;
        do_calc   = 1'b1;
        cc_omega0 = cc_w;
        cc_inv_2q = cc_q;
        pending.push_back(lpf_model(cc_w, cc_q));
        @(posedge reset);
        #1;
        do_calc   = 1'b0;
        // Inputs move on after the strobe and must not reach the result
        cc_omega0 = ~cc_w;
        cc_inv_2q = ~cc_q;
    endtask

    task automatic wait_result();
        while (pending.size() != 0) @(negedge reset);
    endtask

    task automatic run_calc(input logic [6:0] cc_w, input logic [6:0] cc_q);
        issue_calc(cc_w, cc_q);
        wait_result();
    endtask

    initial begin
        logic [6:0] rnd_w;
        logic [6:0] rnd_q;
        logic [6:0] gap;
        do_calc     = 1'b0;
        cc_omega0   = '0;
        cc_inv_2q   = '0;
        held        = '0;
        prev_valid  = 1'b0;
        done_count  = 0;
        cycle_count = 0;
        lfsr_state  = 16'd17236;

        @(negedge clk);
        @(negedge reset);
        check_flag("busy", busy, 1'b0);
        check_flag("coef_valid", coef_valid, 1'b0);
        check_all('0);

        // Corner controller pairs
        run_calc(7'd0, 7'd0);
        run_calc(7'd127, 7'd127);
        run_calc(7'd0, 7'd127);
        run_calc(7'd127, 7'd0);
        run_calc(7'd64, 7'd31);

        // Random pairs with random idle gaps
        for (int i = 0; i < N_RANDOM; i++) begin
            draw_bits(7, rnd_w);
            draw_bits(7, rnd_q);
            draw_bits(4, gap);
            run_calc(rnd_w, rnd_q);
            repeat (gap) @(posedge reset);
        end

        // Strobe while busy must be dropped
        issue_calc(7'd20, 7'd100);
        repeat (3) @(posedge reset);
        #1;
        check_flag("busy", busy, 1'b1);
        do_calc   = 1'b1;
        cc_omega0 = 7'd90;
        cc_inv_2q = 7'd5;
        @(posedge reset);
        #1 do_calc = 1'b0;
        wait_result();

        // Idle long enough to expose a stray result
        repeat (80) @(negedge reset);
        if (pending.size() == 0 && done_count == N_CALCS) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            abort_run($sformatf("Only %0d of %0d calculations completed",
                                done_count, N_CALCS));
        end
    end

endmodule

//--- verilog.f
source/lpf_fixed_pkg.sv
source/lpf_seq_pkg.sv
source/cc_to_omega.sv
source/trig_series.sv
source/recip_divider.sv
source/mac_slice.sv
source/lpf_coef_sequencer.sv
source/lpf_coef_calc.sv
tb/tb_clock_gen.sv
tb/tb_lpf_coef_calc.sv
